// File: hw/tcp_hdr_pkg.sv
package tcp_hdr_pkg;

    // sequence and ack numbers.
    localparam int SEQ_W = 32;
    // payload length in bytes.
    localparam int LEN_W = 16;
    localparam int FLAGS_W = 8;

    // bit positions in the flags byte, standard tcp order.
    localparam int FLAG_ACK = 4;
    localparam int FLAG_PSH = 3;

    // header as seen on the wire after classification.
    typedef struct packed {
        logic [SEQ_W-1:0]   seq_num;
        logic [SEQ_W-1:0]   ack_num;
        logic [FLAGS_W-1:0] flags;
        logic [LEN_W-1:0]   payload_len;
    } tcp_hdr_t;

endpackage

// File: hw/tcp_flow_pkg.sv
package tcp_flow_pkg;
    import tcp_hdr_pkg::*;

    // flowid field of a send packet, wide enough for every flow count.
    localparam int PKT_FLOWID_W = 8;

    // per-flow sequence pointers.
    typedef struct packed {
        logic [SEQ_W-1:0] rcv_nxt;
        logic [SEQ_W-1:0] snd_una;
        logic [SEQ_W-1:0] snd_nxt;
        logic [SEQ_W-1:0] snd_tail;
    } flow_state_t;

    typedef struct packed {
        logic [PKT_FLOWID_W-1:0] flowid;
        tcp_hdr_t                hdr;
    } send_pkt_t;

endpackage

// File: hw/flow_rx_if.sv
`timescale 1ns/10ps

interface flow_rx_if
import tcp_hdr_pkg::*;
import tcp_flow_pkg::*;
#(
     parameter int NUM_FLOWS = 4
    ,localparam int FLOWID_W = $clog2(NUM_FLOWS)
);
    logic   [FLOWID_W-1:0]  rd_flowid;   // also the write address.
    flow_state_t            rd_state;
    logic                   rcv_nxt_wr;
    logic   [SEQ_W-1:0]     rcv_nxt_new;
    logic                   snd_una_wr;
    logic   [SEQ_W-1:0]     snd_una_new;

    modport rx (output rd_flowid, rcv_nxt_wr, rcv_nxt_new, snd_una_wr, snd_una_new,
                input rd_state);
    modport tbl (input rd_flowid, rcv_nxt_wr, rcv_nxt_new, snd_una_wr, snd_una_new,
                 output rd_state);
endinterface

// File: hw/flow_tx_if.sv
`timescale 1ns/10ps

interface flow_tx_if
import tcp_hdr_pkg::*;
import tcp_flow_pkg::*;
#(
     parameter int NUM_FLOWS = 4
    ,localparam int FLOWID_W = $clog2(NUM_FLOWS)
);
    logic   [FLOWID_W-1:0]  rd_flowid;
    flow_state_t            rd_state;
    logic                   snd_nxt_wr;
    logic   [SEQ_W-1:0]     snd_nxt_new;
    // one bit per flow with bytes that may go out now.
    logic   [NUM_FLOWS-1:0] sendable;

    modport tx (output rd_flowid, snd_nxt_wr, snd_nxt_new,
                input rd_state, sendable);
    modport tbl (input rd_flowid, snd_nxt_wr, snd_nxt_new,
                 output rd_state, sendable);
endinterface

// File: hw/flow_state_table.sv
`timescale 1ns/10ps

module flow_state_table
import tcp_hdr_pkg::*;
import tcp_flow_pkg::*;
#(
     parameter int NUM_FLOWS = 4
    ,parameter int TX_WINDOW = 128
    ,localparam int FLOWID_W = $clog2(NUM_FLOWS)
)(
     input  logic                   clk
    ,input  logic                   reset

    ,flow_rx_if.tbl                 rx_port
    ,flow_tx_if.tbl                 tx_port

    ,input  logic                   tail_wr_val
    ,input  logic   [FLOWID_W-1:0]  tail_wr_flowid
    ,input  logic   [SEQ_W-1:0]     tail_wr_data
);

    flow_state_t flows [NUM_FLOWS];

    // each field has a single writer, so no write ever collides.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_FLOWS; i++) begin
                flows[i] <= '0;
            end
        end else begin
            if (rx_port.rcv_nxt_wr) flows[rx_port.rd_flowid].rcv_nxt <= rx_port.rcv_nxt_new;
            if (rx_port.snd_una_wr) flows[rx_port.rd_flowid].snd_una <= rx_port.snd_una_new;
            if (tx_port.snd_nxt_wr) flows[tx_port.rd_flowid].snd_nxt <= tx_port.snd_nxt_new;
            if (tail_wr_val) flows[tail_wr_flowid].snd_tail <= tail_wr_data;
        end
    end

    assign rx_port.rd_state = flows[rx_port.rd_flowid];
    assign tx_port.rd_state = flows[tx_port.rd_flowid];

    // unsent bytes and room left in the window.
    always_comb begin
        for (int i = 0; i < NUM_FLOWS; i++) begin
            tx_port.sendable[i] = (flows[i].snd_nxt != flows[i].snd_tail)
                && ((flows[i].snd_nxt - flows[i].snd_una) < SEQ_W'(TX_WINDOW));
        end
    end

endmodule

// File: hw/tcp_rx_proc.sv
`timescale 1ns/10ps

module tcp_rx_proc
import tcp_hdr_pkg::*;
import tcp_flow_pkg::*;
#(
     parameter int NUM_FLOWS = 4
    ,localparam int FLOWID_W = $clog2(NUM_FLOWS)
)(
     input  logic                   clk
    ,input  logic                   reset

    ,input  logic                   hdr_val
    ,input  logic   [FLOWID_W-1:0]  hdr_flowid
    ,input  tcp_hdr_t               hdr
    ,output logic                   hdr_rdy

    ,flow_rx_if.rx                  tbl

    ,output logic                   ack_val
    ,output send_pkt_t              ack_pkt
    ,input  logic                   ack_rdy

    ,output logic                   dst_val
    ,output logic   [FLOWID_W-1:0]  dst_flowid
    ,output logic                   dst_accept
    ,output logic   [LEN_W-1:0]     dst_len
    ,input  logic                   dst_rdy
);

    typedef enum logic [1:0] {IDLE, PROC, WAIT} rx_state_e;

    rx_state_e              state;
    tcp_hdr_t               hdr_r;
    logic   [FLOWID_W-1:0]  flowid_r;
    flow_state_t            cur;
    logic                   in_order;
    logic                   ack_ok;
    logic   [SEQ_W-1:0]     rcv_nxt_upd;
    logic   [SEQ_W-1:0]     ack_adv;

    assign hdr_rdy = (state == IDLE);

    assign tbl.rd_flowid = flowid_r;
    assign cur = tbl.rd_state;

    assign in_order = (hdr_r.seq_num == cur.rcv_nxt) && (hdr_r.payload_len != '0);
    assign rcv_nxt_upd = in_order ? cur.rcv_nxt + SEQ_W'(hdr_r.payload_len) : cur.rcv_nxt;

    // ack must land in (snd_una, snd_nxt], compared modulo the sequence space.
    assign ack_adv = hdr_r.ack_num - cur.snd_una;
    assign ack_ok = hdr_r.flags[FLAG_ACK] && (ack_adv != '0)
                 && (ack_adv <= (cur.snd_nxt - cur.snd_una));

    assign tbl.rcv_nxt_wr  = (state == PROC) && in_order;
    assign tbl.rcv_nxt_new = rcv_nxt_upd;
    assign tbl.snd_una_wr  = (state == PROC) && ack_ok;
    assign tbl.snd_una_new = hdr_r.ack_num;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            ack_val <= 1'b0;
            dst_val <= 1'b0;
        end else begin
            case (state)
                IDLE: if (hdr_val) state <= PROC;
                PROC: begin
                    state   <= WAIT;
                    ack_val <= (hdr_r.payload_len != '0); // pure acks get no reply.
                    dst_val <= 1'b1;
                end
                WAIT: begin
                    if (ack_rdy) ack_val <= 1'b0;
                    if (dst_rdy) dst_val <= 1'b0;
                    if ((!ack_val || ack_rdy) && (!dst_val || dst_rdy)) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_val && hdr_rdy) begin
            hdr_r    <= hdr;
            flowid_r <= hdr_flowid;
        end
        if (state == PROC) begin
            ack_pkt.flowid              <= PKT_FLOWID_W'(flowid_r);
            ack_pkt.hdr.seq_num         <= cur.snd_nxt;
            ack_pkt.hdr.ack_num         <= rcv_nxt_upd;
            ack_pkt.hdr.flags           <= '0;
            ack_pkt.hdr.flags[FLAG_ACK] <= 1'b1;
            ack_pkt.hdr.payload_len     <= '0;
            dst_flowid                  <= flowid_r;
            dst_accept                  <= in_order;
            dst_len                     <= hdr_r.payload_len;
        end
    end

endmodule

// File: hw/tx_rr_sched.sv
`timescale 1ns/10ps

module tx_rr_sched #(
     parameter int NUM_FLOWS = 4
    ,localparam int FLOWID_W = $clog2(NUM_FLOWS)
)(
     input  logic                   clk
    ,input  logic                   reset

    ,input  logic   [NUM_FLOWS-1:0] sendable
    ,input  logic                   advance

    ,output logic                   grant_val
    ,output logic   [FLOWID_W-1:0]  grant_flowid
);

    logic   [FLOWID_W-1:0]  last_r;
    logic   [FLOWID_W-1:0]  idx;

    // scan from the flow after the last one served, wrapping at NUM_FLOWS.
    always_comb begin
        grant_val    = 1'b0;
        grant_flowid = '0;
        idx          = '0;
        for (int i = 1; i <= NUM_FLOWS; i++) begin
            idx = last_r + FLOWID_W'(i);
            if (!grant_val && sendable[idx]) begin
                grant_val    = 1'b1;
                grant_flowid = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_r <= FLOWID_W'(NUM_FLOWS - 1); // flow 0 goes first.
        end else if (advance) begin
            last_r <= grant_flowid;
        end
    end

endmodule

// File: hw/tcp_tx_fsm.sv
`timescale 1ns/10ps

module tcp_tx_fsm
import tcp_hdr_pkg::*;
import tcp_flow_pkg::*;
#(
     parameter int NUM_FLOWS = 4
    ,parameter int MSS = 64
    ,parameter int TX_WINDOW = 128
    ,localparam int FLOWID_W = $clog2(NUM_FLOWS)
)(
     input  logic                   clk
    ,input  logic                   reset

    ,input  logic                   grant_val
    ,input  logic   [FLOWID_W-1:0]  grant_flowid
    ,output logic                   advance

    ,flow_tx_if.tx                  tbl

    ,output logic                   pkt_val
    ,output send_pkt_t              pkt
    ,input  logic                   pkt_rdy
);

    typedef enum logic [1:0] {IDLE, SEND, SETTLE} tx_state_e;

    tx_state_e              state;
    logic   [FLOWID_W-1:0]  flowid_r;
    flow_state_t            cur;
    logic   [SEQ_W-1:0]     remain;
    logic   [SEQ_W-1:0]     win_left;
    logic   [SEQ_W-1:0]     seg_len;

    // in IDLE the table is read for the flow being granted.
    assign tbl.rd_flowid = (state == IDLE) ? grant_flowid : flowid_r;
    assign cur = tbl.rd_state;

    assign remain   = cur.snd_tail - cur.snd_nxt;
    assign win_left = SEQ_W'(TX_WINDOW) - (cur.snd_nxt - cur.snd_una);

    always_comb begin
        seg_len = remain;
        if (SEQ_W'(MSS) < seg_len) seg_len = SEQ_W'(MSS);
        if (win_left < seg_len) seg_len = win_left;
    end

    assign advance = (state == IDLE) && grant_val;
    assign pkt_val = (state == SEND);

    assign tbl.snd_nxt_wr  = pkt_val && pkt_rdy;
    assign tbl.snd_nxt_new = pkt.hdr.seq_num + SEQ_W'(pkt.hdr.payload_len);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (grant_val) state <= SEND;
                SEND:    if (pkt_rdy) state <= SETTLE;
                SETTLE:  state <= IDLE; // lets sendable catch up with snd_nxt.
                default: state <= IDLE;
            endcase
        end
    end

    // segment is frozen at grant so it stays stable under back-pressure.
    always_ff @(posedge clk) begin
        if (advance) begin
            flowid_r                    <= grant_flowid;
            pkt.flowid                  <= PKT_FLOWID_W'(grant_flowid);
            pkt.hdr.seq_num             <= cur.snd_nxt;
            pkt.hdr.ack_num             <= cur.rcv_nxt;
            pkt.hdr.flags               <= '0;
            pkt.hdr.flags[FLAG_ACK]     <= 1'b1;
            pkt.hdr.flags[FLAG_PSH]     <= 1'b1;
            pkt.hdr.payload_len         <= LEN_W'(seg_len);
        end
    end

endmodule

// File: hw/send_pkt_mux.sv
`timescale 1ns/10ps

module send_pkt_mux
import tcp_flow_pkg::*;
(
     input  logic       clk
    ,input  logic       reset

    ,input  logic       src0_val
    ,input  send_pkt_t  src0_pkt
    ,output logic       src0_rdy

    ,input  logic       src1_val
    ,input  send_pkt_t  src1_pkt
    ,output logic       src1_rdy

    ,output logic       dst_val
    ,output send_pkt_t  dst_pkt
    ,input  logic       dst_rdy
);

    logic prio_r;   // source that wins the next tie.
    logic lock_r;   // output stalled last cycle.
    logic sel_r;
    logic sel_free;
    logic sel;

    assign sel_free = (src0_val && src1_val) ? prio_r : src1_val;
    assign sel      = lock_r ? sel_r : sel_free;

    assign dst_val  = sel ? src1_val : src0_val;
    assign dst_pkt  = sel ? src1_pkt : src0_pkt;
    assign src0_rdy = dst_rdy && !sel;
    assign src1_rdy = dst_rdy && sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_r <= 1'b0;
            lock_r <= 1'b0;
            sel_r  <= 1'b0;
        end else begin
            lock_r <= dst_val && !dst_rdy;
            sel_r  <= sel;
            if (dst_val && dst_rdy) prio_r <= ~sel;
        end
    end

endmodule

// File: hw/tcp_engine.sv
`timescale 1ns/10ps

module tcp_engine
import tcp_hdr_pkg::*;
import tcp_flow_pkg::*;
#(
     parameter int NUM_FLOWS = 4
    ,parameter int MSS = 64
    ,parameter int TX_WINDOW = 128
    ,localparam int FLOWID_W = $clog2(NUM_FLOWS)
)(
     input  logic                   clk
    ,input  logic                   reset

    ,input  logic                   rx_hdr_val
    ,input  logic   [FLOWID_W-1:0]  rx_hdr_flowid
    ,input  logic   [SEQ_W-1:0]     rx_hdr_seq
    ,input  logic   [SEQ_W-1:0]     rx_hdr_ack
    ,input  logic   [FLAGS_W-1:0]   rx_hdr_flags
    ,input  logic   [LEN_W-1:0]     rx_hdr_len
    ,output logic                   rx_hdr_rdy

    ,output logic                   rx_dst_val
    ,output logic   [FLOWID_W-1:0]  rx_dst_flowid
    ,output logic                   rx_dst_accept
    ,output logic   [LEN_W-1:0]     rx_dst_len
    ,input  logic                   rx_dst_rdy

    ,input  logic                   app_tx_tail_wr_val
    ,input  logic   [FLOWID_W-1:0]  app_tx_tail_wr_flowid
    ,input  logic   [SEQ_W-1:0]     app_tx_tail_wr_data

    ,output logic                   tx_pkt_val
    ,output logic   [FLOWID_W-1:0]  tx_pkt_flowid
    ,output logic   [SEQ_W-1:0]     tx_pkt_seq
    ,output logic   [SEQ_W-1:0]     tx_pkt_ack
    ,output logic   [FLAGS_W-1:0]   tx_pkt_flags
    ,output logic   [LEN_W-1:0]     tx_pkt_len
    ,input  logic                   tx_pkt_rdy
);

    tcp_hdr_t               rx_hdr;
    send_pkt_t              tx_pkt;
    logic                   ack_val;
    send_pkt_t              ack_pkt;
    logic                   ack_rdy;
    logic                   seg_val;
    send_pkt_t              seg_pkt;
    logic                   seg_rdy;
    logic                   grant_val;
    logic   [FLOWID_W-1:0]  grant_flowid;
    logic                   advance;

    flow_rx_if #(.NUM_FLOWS(NUM_FLOWS)) rx_tbl_if ();
    flow_tx_if #(.NUM_FLOWS(NUM_FLOWS)) tx_tbl_if ();

    assign rx_hdr = '{seq_num: rx_hdr_seq, ack_num: rx_hdr_ack,
                      flags: rx_hdr_flags, payload_len: rx_hdr_len};

    assign tx_pkt_flowid = tx_pkt.flowid[FLOWID_W-1:0];
    assign tx_pkt_seq    = tx_pkt.hdr.seq_num;
    assign tx_pkt_ack    = tx_pkt.hdr.ack_num;
    assign tx_pkt_flags  = tx_pkt.hdr.flags;
    assign tx_pkt_len    = tx_pkt.hdr.payload_len;

    flow_state_table #(
         .NUM_FLOWS (NUM_FLOWS  )
        ,.TX_WINDOW (TX_WINDOW  )
    ) state_table (
         .clk               (clk                    )
        ,.reset             (reset                  )
        ,.rx_port           (rx_tbl_if              )
        ,.tx_port           (tx_tbl_if              )
        ,.tail_wr_val       (app_tx_tail_wr_val     )
        ,.tail_wr_flowid    (app_tx_tail_wr_flowid  )
        ,.tail_wr_data      (app_tx_tail_wr_data    )
    );

    tcp_rx_proc #(
        .NUM_FLOWS  (NUM_FLOWS  )
    ) rx_proc (
         .clk           (clk            )
        ,.reset         (reset          )
        ,.hdr_val       (rx_hdr_val     )
        ,.hdr_flowid    (rx_hdr_flowid  )
        ,.hdr           (rx_hdr         )
        ,.hdr_rdy       (rx_hdr_rdy     )
        ,.tbl           (rx_tbl_if      )
        ,.ack_val       (ack_val        )
        ,.ack_pkt       (ack_pkt        )
        ,.ack_rdy       (ack_rdy        )
        ,.dst_val       (rx_dst_val     )
        ,.dst_flowid    (rx_dst_flowid  )
        ,.dst_accept    (rx_dst_accept  )
        ,.dst_len       (rx_dst_len     )
        ,.dst_rdy       (rx_dst_rdy     )
    );

    tx_rr_sched #(
        .NUM_FLOWS  (NUM_FLOWS  )
    ) tx_sched (
         .clk           (clk                )
        ,.reset         (reset              )
        ,.sendable      (tx_tbl_if.sendable )
        ,.advance       (advance            )
        ,.grant_val     (grant_val          )
        ,.grant_flowid  (grant_flowid       )
    );

    tcp_tx_fsm #(
         .NUM_FLOWS (NUM_FLOWS  )
        ,.MSS       (MSS        )
        ,.TX_WINDOW (TX_WINDOW  )
    ) tx_fsm (
         .clk           (clk            )
        ,.reset         (reset          )
        ,.grant_val     (grant_val      )
        ,.grant_flowid  (grant_flowid   )
        ,.advance       (advance        )
        ,.tbl           (tx_tbl_if      )
        ,.pkt_val       (seg_val        )
        ,.pkt           (seg_pkt        )
        ,.pkt_rdy       (seg_rdy        )
    );

    // acks on source 0, data segments on source 1.
    send_pkt_mux tx_mux (
         .clk       (clk        )
        ,.reset     (reset      )
        ,.src0_val  (ack_val    )
        ,.src0_pkt  (ack_pkt    )
        ,.src0_rdy  (ack_rdy    )
        ,.src1_val  (seg_val    )
        ,.src1_pkt  (seg_pkt    )
        ,.src1_rdy  (seg_rdy    )
        ,.dst_val   (tx_pkt_val )
        ,.dst_pkt   (tx_pkt     )
        ,.dst_rdy   (tx_pkt_rdy )
    );

endmodule

// File: verif/tcp_engine_tb.sv
`timescale 1ns/10ps

module tcp_engine_tb
import tcp_hdr_pkg::*;
();

    localparam int NUM_FLOWS = 4;
    localparam int MSS = 64;
    localparam int TX_WINDOW = 128;
    localparam int NUM_RX = 12;
    localparam int WAIT_LIMIT = 2000;
    localparam int RUN_LIMIT = 50000;
    localparam logic [7:0] ACK_ONLY = 8'(1 << FLAG_ACK);
    localparam logic [7:0] ACK_PSH = 8'((1 << FLAG_ACK) | (1 << FLAG_PSH));

    logic           clk = 1'b0;
    logic           reset;
    logic           rx_hdr_val;
    logic   [1:0]   rx_hdr_flowid;
    logic   [31:0]  rx_hdr_seq;
    logic   [31:0]  rx_hdr_ack;
    logic   [7:0]   rx_hdr_flags;
    logic   [15:0]  rx_hdr_len;
    logic           rx_hdr_rdy;
    logic           rx_dst_val;
    logic   [1:0]   rx_dst_flowid;
    logic           rx_dst_accept;
    logic   [15:0]  rx_dst_len;
    logic           rx_dst_rdy;
    logic           app_tx_tail_wr_val;
    logic   [1:0]   app_tx_tail_wr_flowid;
    logic   [31:0]  app_tx_tail_wr_data;
    logic           tx_pkt_val;
    logic   [1:0]   tx_pkt_flowid;
    logic   [31:0]  tx_pkt_seq;
    logic   [31:0]  tx_pkt_ack;
    logic   [7:0]   tx_pkt_flags;
    logic   [15:0]  tx_pkt_len;
    logic           tx_pkt_rdy;
    logic   [89:0]  tx_word;

    // reference model of the per-flow pointers.
    logic   [31:0]  m_rcv_nxt [NUM_FLOWS];
    logic   [31:0]  m_snd_una [NUM_FLOWS];
    logic   [31:0]  m_snd_nxt [NUM_FLOWS];
    logic   [31:0]  m_tail [NUM_FLOWS];

    // expected acks and buffer copies, oldest first.
    logic   [1:0]   exp_ack_flow [$];
    logic   [31:0]  exp_ack_seq [$];
    logic   [31:0]  exp_ack_num [$];
    logic   [1:0]   exp_dst_flow [$];
    logic           exp_dst_accept [$];
    logic   [15:0]  exp_dst_len [$];

    logic   [31:0]  lfsr = 32'h4e68ca38;
    logic           stall_a;
    logic           stall_b;
    logic           stalled = 1'b0;
    logic   [89:0]  held_word;
    logic           fair_check = 1'b0;
    logic           run_done = 1'b0;
    int             last_flow = -1;
    int             seg_count = 0;
    int             errors = 0;
    int             timeouts = 0;

    logic   [0:0]   rx_flow [NUM_RX];
    logic   [1:0]   rx_mode [NUM_RX];
    logic   [15:0]  rx_len [NUM_RX];
    logic   [31:0]  tail0;
    logic   [31:0]  tail2;
    logic   [31:0]  tail3;

    always #4 clk = ~clk;

    tcp_engine #(
         .NUM_FLOWS (NUM_FLOWS  )
        ,.MSS       (MSS        )
        ,.TX_WINDOW (TX_WINDOW  )
    ) tcp_engine_inst (
         .clk                   (clk                    )
        ,.reset                 (reset                  )
        ,.rx_hdr_val            (rx_hdr_val             )
        ,.rx_hdr_flowid         (rx_hdr_flowid          )
        ,.rx_hdr_seq            (rx_hdr_seq             )
        ,.rx_hdr_ack            (rx_hdr_ack             )
        ,.rx_hdr_flags          (rx_hdr_flags           )
        ,.rx_hdr_len            (rx_hdr_len             )
        ,.rx_hdr_rdy            (rx_hdr_rdy             )
        ,.rx_dst_val            (rx_dst_val             )
        ,.rx_dst_flowid         (rx_dst_flowid          )
        ,.rx_dst_accept         (rx_dst_accept          )
        ,.rx_dst_len            (rx_dst_len             )
        ,.rx_dst_rdy            (rx_dst_rdy             )
        ,.app_tx_tail_wr_val    (app_tx_tail_wr_val     )
        ,.app_tx_tail_wr_flowid (app_tx_tail_wr_flowid  )
        ,.app_tx_tail_wr_data   (app_tx_tail_wr_data    )
        ,.tx_pkt_val            (tx_pkt_val             )
        ,.tx_pkt_flowid         (tx_pkt_flowid          )
        ,.tx_pkt_seq            (tx_pkt_seq             )
        ,.tx_pkt_ack            (tx_pkt_ack             )
        ,.tx_pkt_flags          (tx_pkt_flags           )
        ,.tx_pkt_len            (tx_pkt_len             )
        ,.tx_pkt_rdy            (tx_pkt_rdy             )
    );

    assign tx_word = {tx_pkt_flowid, tx_pkt_seq, tx_pkt_ack, tx_pkt_flags, tx_pkt_len};

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32, 22, 2, 1.
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic model_sendable(input int g);
        return (m_snd_nxt[g] != m_tail[g]) && ((m_snd_nxt[g] - m_snd_una[g]) < TX_WINDOW);
    endfunction

    task automatic end_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timeouts++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_data_seg();
        int f;
        f = tx_pkt_flowid;
        compare_value("data_seq", m_snd_nxt[f], tx_pkt_seq);
        compare_value("data_ack", m_rcv_nxt[f], tx_pkt_ack);
        compare_value("data_flags", ACK_PSH, tx_pkt_flags);
        assert (tx_pkt_len != 0 && tx_pkt_len <= MSS) else begin
            errors++;
            $display("** Error data_len: expected 1 to %0d, actual %0d", MSS, tx_pkt_len);
        end
        assert (32'(tx_pkt_len) <= m_tail[f] - m_snd_nxt[f]) else begin
            errors++;
            $display("** Error data_tail: expected at most %0d, actual %0d",
                     m_tail[f] - m_snd_nxt[f], tx_pkt_len);
        end
        assert (m_snd_nxt[f] + 32'(tx_pkt_len) - m_snd_una[f] <= TX_WINDOW) else begin
            errors++;
            $display("** Error data_window: expected at most %0d, actual %0d", TX_WINDOW,
                     m_snd_nxt[f] + 32'(tx_pkt_len) - m_snd_una[f]);
        end
        if (fair_check && last_flow == f) begin
            for (int g = 0; g < NUM_FLOWS; g++) begin
                assert (g == f || !model_sendable(g)) else begin
                    errors++;
                    $display("flow %0d got two segments in a row while flow %0d waited", f, g);
                end
            end
        end
        last_flow = f;
        m_snd_nxt[f] = m_snd_nxt[f] + 32'(tx_pkt_len);
        seg_count++;
    endtask

    task automatic check_ack_pkt();
        assert (exp_ack_seq.size() != 0) else begin
            errors++;
            $display("ack packet on flow %0d with no header behind it", tx_pkt_flowid);
        end
        if (exp_ack_seq.size() != 0) begin
            compare_value("ack_flow", exp_ack_flow.pop_front(), tx_pkt_flowid);
            compare_value("ack_seq", exp_ack_seq.pop_front(), tx_pkt_seq);
            compare_value("ack_num", exp_ack_num.pop_front(), tx_pkt_ack);
            compare_value("ack_flags", ACK_ONLY, tx_pkt_flags);
            compare_value("ack_len", 0, tx_pkt_len);
        end
    endtask

    task automatic check_dst();
        assert (exp_dst_len.size() != 0) else begin
            errors++;
            $display("buffer copy on flow %0d with no header behind it", rx_dst_flowid);
        end
        if (exp_dst_len.size() != 0) begin
            compare_value("dst_flow", exp_dst_flow.pop_front(), rx_dst_flowid);
            compare_value("dst_accept", exp_dst_accept.pop_front(), rx_dst_accept);
            compare_value("dst_len", exp_dst_len.pop_front(), rx_dst_len);
        end
    endtask

    // output monitor, everything sampled on the rising edge.
    always @(posedge clk) begin
        if (!reset) begin
            if (stalled) begin
                assert (tx_word == held_word) else begin
                    errors++;
                    $display("** Error tx_hold: expected %h, actual %h", held_word, tx_word);
                end
            end
            stalled = tx_pkt_val && !tx_pkt_rdy;
            held_word = tx_word;
            if (tx_pkt_val && tx_pkt_rdy) begin
                if (tx_pkt_flags[FLAG_PSH]) check_data_seg();
                else check_ack_pkt();
            end
            if (rx_dst_val && rx_dst_rdy) check_dst();
        end
    end

    tx_val_hold: assert property (@(posedge clk) disable iff (reset)
            (tx_pkt_val && !tx_pkt_rdy) |=> tx_pkt_val)
        else begin
            errors++;
            $display("tx_pkt_val dropped while tx_pkt_rdy was low");
        end

    dst_val_hold: assert property (@(posedge clk) disable iff (reset)
            (rx_dst_val && !rx_dst_rdy) |=> rx_dst_val)
        else begin
            errors++;
            $display("rx_dst_val dropped while rx_dst_rdy was low");
        end

    // output stalls, about one cycle in four.
    always @(negedge clk) begin
        stall_a = lfsr_step();
        stall_b = lfsr_step();
        tx_pkt_rdy = stall_a | stall_b;
        stall_a = lfsr_step();
        stall_b = lfsr_step();
        rx_dst_rdy = stall_a | stall_b;
    end

    task automatic wait_hdr_rdy();
        int cycles;
        cycles = 0;
        while (!rx_hdr_rdy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rx_hdr_rdy) report_timeout("rx_hdr_rdy");
    endtask

    task automatic wait_snd_nxt(input int f, input logic [31:0] target);
        int cycles;
        cycles = 0;
        while (m_snd_nxt[f] != target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (m_snd_nxt[f] != target) report_timeout("data segments");
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((exp_ack_seq.size() != 0 || exp_dst_len.size() != 0) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_ack_seq.size() != 0 || exp_dst_len.size() != 0) report_timeout("acks");
    endtask

    // no data segment may go out during the quiet period.
    task automatic quiet_check(input string name, input int cycles);
        int count0;
        count0 = seg_count;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
        compare_value(name, count0, seg_count);
    endtask

    task automatic send_header(input int f, input logic [31:0] seq, input logic [31:0] ack,
                               input logic [7:0] flags, input logic [15:0] len);
        logic in_order;
        wait_hdr_rdy();
        in_order = (seq == m_rcv_nxt[f]) && (len != 0);
        if (in_order) m_rcv_nxt[f] = m_rcv_nxt[f] + 32'(len);
        // an ack moves snd_una only from inside (snd_una, snd_nxt].
        if (flags[FLAG_ACK] && ack > m_snd_una[f] && ack <= m_snd_nxt[f]) begin
            m_snd_una[f] = ack;
        end
        exp_dst_flow.push_back(2'(f));
        exp_dst_accept.push_back(in_order);
        exp_dst_len.push_back(len);
        if (len != 0) begin
            exp_ack_flow.push_back(2'(f));
            exp_ack_seq.push_back(m_snd_nxt[f]);
            exp_ack_num.push_back(m_rcv_nxt[f]);
        end
        rx_hdr_flowid = 2'(f);
        rx_hdr_seq    = seq;
        rx_hdr_ack    = ack;
        rx_hdr_flags  = flags;
        rx_hdr_len    = len;
        rx_hdr_val    = 1'b1;
        @(negedge clk);
        rx_hdr_val = 1'b0;
    endtask

    task automatic write_tail(input int f, input logic [31:0] tail);
        app_tx_tail_wr_flowid = 2'(f);
        app_tx_tail_wr_data   = tail;
        app_tx_tail_wr_val    = 1'b1;
        m_tail[f] = tail;
        @(negedge clk);
        app_tx_tail_wr_val = 1'b0;
    endtask

    // run ends once the stimulus is done or a wait has timed out.
    initial begin
        int cycles;
        cycles = 0;
        while (!run_done && timeouts == 0 && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!run_done && timeouts == 0) report_timeout("end of stimulus");
        end_run();
    end

    initial begin
        int          f;
        logic [31:0] seq;
        for (int i = 0; i < NUM_RX; i++) begin
            rx_flow[i] = 1'(rand_bits(1));
            rx_mode[i] = 2'(rand_bits(2));
            rx_len[i]  = 16'(rand_bits(7)) + 16'd1;
        end
        rx_mode[0] = 2'd2;  // at least one of each kind.
        rx_mode[1] = 2'd0;
        rx_mode[2] = 2'd1;
        tail0 = rand_bits(7) + 32'd1;
        tail2 = rand_bits(5) + 32'd97;
        tail3 = rand_bits(5) + 32'd97;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            m_rcv_nxt[i] = '0;
            m_snd_una[i] = '0;
            m_snd_nxt[i] = '0;
            m_tail[i]    = '0;
        end
        reset = 1'b1;
        rx_hdr_val = 1'b0;
        rx_hdr_flowid = '0;
        rx_hdr_seq = '0;
        rx_hdr_ack = '0;
        rx_hdr_flags = '0;
        rx_hdr_len = '0;
        rx_dst_rdy = 1'b0;
        app_tx_tail_wr_val = 1'b0;
        app_tx_tail_wr_flowid = '0;
        app_tx_tail_wr_data = '0;
        tx_pkt_rdy = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        compare_value("reset_tx_pkt_val", 0, tx_pkt_val);
        compare_value("reset_rx_dst_val", 0, rx_dst_val);
        wait_hdr_rdy();

        // in-order, repeated and early segments on flows 0 and 1.
        for (int i = 0; i < NUM_RX; i++) begin
            f = rx_flow[i];
            case (rx_mode[i])
                2'd0:    seq = m_rcv_nxt[f] - 32'(rx_len[i]);
                2'd1:    seq = m_rcv_nxt[f] + 32'(rx_len[i]);
                default: seq = m_rcv_nxt[f];
            endcase
            send_header(f, seq, 32'd0, 8'h00, rx_len[i]);
        end
        wait_drained();

        write_tail(0, tail0);
        wait_snd_nxt(0, tail0);
        quiet_check("tail_sum", 20);

        write_tail(1, 32'd300);
        wait_snd_nxt(1, TX_WINDOW);
        quiet_check("window_stop", 40);
        send_header(1, m_rcv_nxt[1], 32'd64, ACK_ONLY, 16'd0);
        wait_snd_nxt(1, 32'd192);
        quiet_check("window_reopen", 40);
        send_header(1, m_rcv_nxt[1], 32'd192, ACK_ONLY, 16'd0);
        wait_snd_nxt(1, 32'd300);
        send_header(1, m_rcv_nxt[1], 32'd350, ACK_ONLY, 16'd0); // beyond snd_nxt.
        wait_drained();
        write_tail(1, 32'd400);
        wait_snd_nxt(1, 32'd320); // only 20 bytes of window left.
        quiet_check("ack_out_of_range", 40);
        wait_drained();

        fair_check = 1'b1;
        last_flow = -1;
        write_tail(2, tail2);
        write_tail(3, tail3);
        wait_snd_nxt(2, tail2);
        wait_snd_nxt(3, tail3);
        fair_check = 1'b0;
        wait_drained();
        run_done = 1'b1;
    end

endmodule

// File: tb.f
hw/tcp_hdr_pkg.sv
hw/tcp_flow_pkg.sv
hw/flow_rx_if.sv
hw/flow_tx_if.sv
hw/flow_state_table.sv
hw/tcp_rx_proc.sv
hw/tx_rr_sched.sv
hw/tcp_tx_fsm.sv
hw/send_pkt_mux.sv
hw/tcp_engine.sv
verif/tcp_engine_tb.sv

// File: Bender.yml
package:
  name: tcp_engine

sources:
  - hw/tcp_hdr_pkg.sv
  - hw/tcp_flow_pkg.sv
  - hw/flow_rx_if.sv
  - hw/flow_tx_if.sv
  - hw/flow_state_table.sv
  - hw/tcp_rx_proc.sv
  - hw/tx_rr_sched.sv
  - hw/tcp_tx_fsm.sv
  - hw/send_pkt_mux.sv
  - hw/tcp_engine.sv
  - target: simulation
    files:
      - verif/tcp_engine_tb.sv
